//--- hw/draw_pkg.sv
`default_nettype none

package draw_pkg;

    //////////////////////////////////////////////////////////////////////
    // basic types
    //////////////////////////////////////////////////////////////////////

    typedef logic [10:0] coord_t;   // pixel counter
    typedef logic [11:0] rgb_t;     // 4 bits per channel, r g b

    typedef enum logic [1:0]
    {
        SCREEN_START,
        SCREEN_CHOICE,
        SCREEN_BLANK
    } screen_t;

    typedef enum logic
    {
        STROKE_H,
        STROKE_V
    } stroke_dir_t;

    // pos is y for a horizontal stroke, x for a vertical one
    typedef struct packed
    {
        stroke_dir_t dir;
        coord_t      pos;
        coord_t      span_lo;       // inclusive
        coord_t      span_hi;       // inclusive
    } stroke_t;

    //////////////////////////////////////////////////////////////////////
    // title: block letters T I C T A C T O E
    //////////////////////////////////////////////////////////////////////

    localparam coord_t TITLE_X_OFS = 11'd100;
    localparam coord_t TITLE_Y_OFS = 11'd100;
    localparam int     NUM_STROKES = 25;

    // coordinates before offset, rows 100 / 150 / 200
    localparam stroke_t TITLE_STROKES [NUM_STROKES] = '{
        '{STROKE_H, 11'd100, 11'd30,  11'd100},  // T top
        '{STROKE_V, 11'd65,  11'd100, 11'd200},  // T stem
        '{STROKE_V, 11'd120, 11'd100, 11'd200},  // I
        '{STROKE_V, 11'd140, 11'd100, 11'd200},  // C left
        '{STROKE_H, 11'd100, 11'd140, 11'd210},
        '{STROKE_H, 11'd200, 11'd140, 11'd210},
        '{STROKE_H, 11'd100, 11'd250, 11'd320},  // T top
        '{STROKE_V, 11'd285, 11'd100, 11'd200},
        '{STROKE_V, 11'd340, 11'd100, 11'd200},  // A sides
        '{STROKE_V, 11'd410, 11'd100, 11'd200},
        '{STROKE_H, 11'd100, 11'd340, 11'd410},
        '{STROKE_H, 11'd150, 11'd340, 11'd410},  // A middle bar
        '{STROKE_V, 11'd430, 11'd100, 11'd200},  // C left
        '{STROKE_H, 11'd100, 11'd430, 11'd500},
        '{STROKE_H, 11'd200, 11'd430, 11'd500},
        '{STROKE_H, 11'd100, 11'd540, 11'd610},  // T top
        '{STROKE_V, 11'd575, 11'd100, 11'd200},
        '{STROKE_V, 11'd630, 11'd100, 11'd200},  // O sides
        '{STROKE_V, 11'd700, 11'd100, 11'd200},
        '{STROKE_H, 11'd100, 11'd630, 11'd700},
        '{STROKE_H, 11'd200, 11'd630, 11'd700},
        '{STROKE_V, 11'd720, 11'd100, 11'd200},  // E spine
        '{STROKE_H, 11'd100, 11'd720, 11'd790},
        '{STROKE_H, 11'd150, 11'd720, 11'd790},
        '{STROKE_H, 11'd200, 11'd720, 11'd790}
    };

    //////////////////////////////////////////////////////////////////////
    // tiles, bounds inclusive
    //////////////////////////////////////////////////////////////////////

    localparam coord_t START_TILE_X0   = 11'd320;
    localparam coord_t START_TILE_X1   = 11'd480;
    localparam coord_t START_TILE_Y0   = 11'd400;
    localparam coord_t START_TILE_YMID = 11'd480;  // last yellow row
    localparam coord_t START_TILE_Y1   = 11'd560;

    localparam coord_t CHOICE_TILE_Y0   = 11'd450;
    localparam coord_t CHOICE_TILE_Y1   = 11'd550;
    localparam coord_t CHOICE_LEFT_X0   = 11'd300;
    localparam coord_t CHOICE_LEFT_X1   = 11'd400;
    localparam coord_t CHOICE_RIGHT_X0  = 11'd650;
    localparam coord_t CHOICE_RIGHT_X1  = 11'd750;

    //////////////////////////////////////////////////////////////////////
    // caption boxes, upper bounds exclusive
    //////////////////////////////////////////////////////////////////////

    localparam coord_t START_CAP_X  = 11'd490;
    localparam coord_t START_CAP_Y  = 11'd600;
    localparam coord_t START_CAP_W  = 11'd40;
    localparam coord_t CHOICE_CAP_X = 11'd470;
    localparam coord_t CHOICE_CAP_Y = 11'd300;
    localparam coord_t CHOICE_CAP_W = 11'd110;
    localparam coord_t CAP_H        = 11'd15;
    localparam int     GLYPH_W      = 8;

    // colours
    localparam rgb_t RED          = 12'hf00;
    localparam rgb_t YELLOW       = 12'hff0;
    localparam rgb_t BLUE         = 12'h00f;
    localparam rgb_t LETTER_COLOR = 12'h333;
    localparam rgb_t CAPTION_BG   = 12'heee;
    localparam rgb_t BACKGROUND   = 12'h888;

endpackage

`default_nettype wire

//--- hw/vga_timing_if.sv
`timescale 1ns/1ps
`default_nettype none

// one pixel worth of vga timing, as seen at one point of the chain
interface vga_timing_if (input wire pclk);

    import draw_pkg::*;

    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;

    modport src (
        input  pclk,
        output hcount, vcount, hsync, vsync, hblnk, vblnk
    );

    modport snk (
        input  pclk,
        input  hcount, vcount, hsync, vsync, hblnk, vblnk
    );

endinterface

`default_nettype wire

//--- hw/title_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module title_renderer (
    vga_timing_if.snk timing,
    output logic      stroke_hit
);

    import draw_pkg::*;

    logic [NUM_STROKES-1:0] hits;   // one bit per stroke

    // one comparator pair per stroke, table coords shifted by the offset
    for (genvar i = 0; i < NUM_STROKES; i++)
    begin : g_stroke
        localparam stroke_t S = TITLE_STROKES[i];

        if (S.dir == STROKE_H)
        begin : g_horiz
            localparam coord_t ROW = S.pos + TITLE_Y_OFS;
            localparam coord_t LO  = S.span_lo + TITLE_X_OFS;
            localparam coord_t HI  = S.span_hi + TITLE_X_OFS;

            assign hits[i] = (timing.vcount == ROW)
                             && (timing.hcount >= LO)
                             && (timing.hcount <= HI);
        end
        else
        begin : g_vert
            localparam coord_t COL = S.pos + TITLE_X_OFS;
            localparam coord_t LO  = S.span_lo + TITLE_Y_OFS;
            localparam coord_t HI  = S.span_hi + TITLE_Y_OFS;

            assign hits[i] = (timing.hcount == COL)
                             && (timing.vcount >= LO)
                             && (timing.vcount <= HI);
        end
    end

    assign stroke_hit = |hits;

endmodule

`default_nettype wire

//--- hw/caption_locator.sv
`timescale 1ns/1ps
`default_nettype none

module caption_locator (
    vga_timing_if.snk          timing,
    input  wire                start_en,
    input  wire                choice_en,
    input  wire  [7:0]         char_pixels,
    output draw_pkg::screen_t  screen,
    output logic               cap_hit,
    output logic               glyph_on,
    output logic [7:0]         char_xy,
    output logic [3:0]         char_line
);

    import draw_pkg::*;

    coord_t     cap_x0;
    coord_t     cap_y0;
    coord_t     cap_w;          // zero width means no box
    coord_t     row;
    coord_t     col;
    logic [2:0] glyph_bit;

    // start_en low wins over choice_en
    always_comb
    begin
        if (!start_en)
            screen = SCREEN_START;
        else if (choice_en)
            screen = SCREEN_CHOICE;
        else
            screen = SCREEN_BLANK;
    end

    always_comb
    begin
        case (screen)
            SCREEN_START:
            begin
                cap_x0 = START_CAP_X;
                cap_y0 = START_CAP_Y;
                cap_w  = START_CAP_W;
            end
            SCREEN_CHOICE:
            begin
                cap_x0 = CHOICE_CAP_X;
                cap_y0 = CHOICE_CAP_Y;
                cap_w  = CHOICE_CAP_W;
            end
            default:
            begin
                cap_x0 = '0;
                cap_y0 = '0;
                cap_w  = '0;
            end
        endcase
    end

    assign row = timing.vcount - cap_y0;  // box relative
    assign col = timing.hcount - cap_x0;

    assign cap_hit = (timing.vcount >= cap_y0) && (timing.vcount < cap_y0 + CAP_H)
                     && (timing.hcount >= cap_x0) && (timing.hcount < cap_x0 + cap_w);

    // font rom address, 16 rows per glyph
    assign char_xy   = {row[7:4], col[6:3]};
    assign char_line = row[3:0];

    // msb of the font byte is the leftmost column
    assign glyph_bit = 3'(GLYPH_W - 1) - 3'(col % GLYPH_W);
    assign glyph_on  = char_pixels[glyph_bit];

    a_screen_valid : assert property (@(posedge timing.pclk)
        screen inside {SCREEN_START, SCREEN_CHOICE, SCREEN_BLANK})
        else $error("caption_locator: screen out of range");

endmodule

`default_nettype wire

//--- hw/tile_renderer.sv
`timescale 1ns/1ps
`default_nettype none

module tile_renderer (
    vga_timing_if.snk          timing,
    input  wire draw_pkg::screen_t screen,
    output logic               tile_hit,
    output draw_pkg::rgb_t     tile_color
);

    import draw_pkg::*;

    logic in_start_block;
    logic in_choice_rows;
    logic in_left;
    logic in_right;

    // 2x2 block on the start screen
    assign in_start_block = (timing.hcount >= START_TILE_X0)
                            && (timing.hcount <= START_TILE_X1)
                            && (timing.vcount >= START_TILE_Y0)
                            && (timing.vcount <= START_TILE_Y1);

    assign in_choice_rows = (timing.vcount >= CHOICE_TILE_Y0)
                            && (timing.vcount <= CHOICE_TILE_Y1);
    assign in_left  = (timing.hcount >= CHOICE_LEFT_X0) && (timing.hcount <= CHOICE_LEFT_X1);
    assign in_right = (timing.hcount >= CHOICE_RIGHT_X0) && (timing.hcount <= CHOICE_RIGHT_X1);

    always_comb
    begin
        tile_hit   = 1'b0;
        tile_color = '0;
        case (screen)
            SCREEN_START:
            begin
                if (in_start_block)
                begin
                    tile_hit   = 1'b1;
                    tile_color = (timing.vcount <= START_TILE_YMID) ? YELLOW : BLUE;
                end
            end
            SCREEN_CHOICE:
            begin
                if (in_choice_rows && in_left)
                begin
                    tile_hit   = 1'b1;
                    tile_color = BLUE;      // left choice
                end
                else if (in_choice_rows && in_right)
                begin
                    tile_hit   = 1'b1;
                    tile_color = YELLOW;
                end
            end
            default:
            begin
                tile_hit = 1'b0;    // blank screen, nothing drawn
            end
        endcase
    end

    a_no_tile_on_blank : assert property (@(posedge timing.pclk)
        (screen == SCREEN_BLANK) |-> !tile_hit)
        else $error("tile_renderer: tile hit on blank screen");

endmodule

`default_nettype wire

//--- hw/pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer (
    input  wire                    pclk,
    input  wire                    rst,
    vga_timing_if.snk              timing_in,
    input  wire draw_pkg::screen_t screen,
    input  wire                    cap_hit,
    input  wire                    glyph_on,
    input  wire                    stroke_hit,
    input  wire                    tile_hit,
    input  wire draw_pkg::rgb_t    tile_color,
    vga_timing_if.src              timing_out,
    output draw_pkg::rgb_t         rgb_out
);

    import draw_pkg::*;

    rgb_t rgb_nxt;

    //////////////////////////////////////////////////////////////////////
    // colour priority
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        if (cap_hit)
            rgb_nxt = glyph_on ? LETTER_COLOR : CAPTION_BG;
        else if (stroke_hit && (screen == SCREEN_START))
            rgb_nxt = RED;          // title only on start screen
        else if (tile_hit)
            rgb_nxt = tile_color;
        else
            rgb_nxt = BACKGROUND;
    end

    //////////////////////////////////////////////////////////////////////
    // output stage, timing and colour stay aligned
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge pclk)
    begin
        if (rst)
        begin
            timing_out.hcount <= '0;
            timing_out.vcount <= '0;
            timing_out.hsync  <= 1'b0;
            timing_out.vsync  <= 1'b0;
            timing_out.hblnk  <= 1'b0;
            timing_out.vblnk  <= 1'b0;
            rgb_out           <= '0;
        end
        else
        begin
            timing_out.hcount <= timing_in.hcount;
            timing_out.vcount <= timing_in.vcount;
            timing_out.hsync  <= timing_in.hsync;
            timing_out.vsync  <= timing_in.vsync;
            timing_out.hblnk  <= timing_in.hblnk;
            timing_out.vblnk  <= timing_in.vblnk;
            rgb_out           <= rgb_nxt;
        end
    end

    // a reset cycle leaves a quiet output
    a_reset_quiet : assert property (@(posedge pclk)
        rst |=> (!timing_out.hsync && !timing_out.vsync
                 && !timing_out.hblnk && !timing_out.vblnk && (rgb_out == '0)))
        else $error("pixel_mixer: outputs not cleared after reset");

endmodule

`default_nettype wire

//--- hw/draw_screen_top.sv
`timescale 1ns/1ps
`default_nettype none

module draw_screen_top (
    input  wire                   pclk,
    input  wire                   rst,
    input  wire draw_pkg::coord_t hcount_in,
    input  wire draw_pkg::coord_t vcount_in,
    input  wire                   hsync_in,
    input  wire                   vsync_in,
    input  wire                   hblnk_in,
    input  wire                   vblnk_in,
    input  wire                   start_en,
    input  wire                   choice_en,
    input  wire [7:0]             char_pixels,
    output draw_pkg::coord_t      hcount_out,
    output draw_pkg::coord_t      vcount_out,
    output logic                  hsync_out,
    output logic                  vsync_out,
    output logic                  hblnk_out,
    output logic                  vblnk_out,
    output draw_pkg::rgb_t        rgb_out,
    output logic [7:0]            char_xy,
    output logic [3:0]            char_line
);

    import draw_pkg::*;

    screen_t screen;
    logic    cap_hit;
    logic    glyph_on;
    logic    stroke_hit;
    logic    tile_hit;
    rgb_t    tile_color;

    vga_timing_if timing_in (.pclk(pclk));
    vga_timing_if timing_out (.pclk(pclk));

    // incoming pixel
    assign timing_in.hcount = hcount_in;
    assign timing_in.vcount = vcount_in;
    assign timing_in.hsync  = hsync_in;
    assign timing_in.vsync  = vsync_in;
    assign timing_in.hblnk  = hblnk_in;
    assign timing_in.vblnk  = vblnk_in;

    title_renderer u_title (
        .timing     (timing_in),
        .stroke_hit (stroke_hit)
    );

    caption_locator u_caption (
        .timing      (timing_in),
        .start_en    (start_en),
        .choice_en   (choice_en),
        .char_pixels (char_pixels),
        .screen      (screen),
        .cap_hit     (cap_hit),
        .glyph_on    (glyph_on),
        .char_xy     (char_xy),     // to font rom, same cycle
        .char_line   (char_line)
    );

    tile_renderer u_tiles (
        .timing     (timing_in),
        .screen     (screen),
        .tile_hit   (tile_hit),
        .tile_color (tile_color)
    );

    pixel_mixer u_mixer (
        .pclk       (pclk),
        .rst        (rst),
        .timing_in  (timing_in),
        .screen     (screen),
        .cap_hit    (cap_hit),
        .glyph_on   (glyph_on),
        .stroke_hit (stroke_hit),
        .tile_hit   (tile_hit),
        .tile_color (tile_color),
        .timing_out (timing_out),
        .rgb_out    (rgb_out)
    );

    // registered pixel, one cycle later
    assign hcount_out = timing_out.hcount;
    assign vcount_out = timing_out.vcount;
    assign hsync_out  = timing_out.hsync;
    assign vsync_out  = timing_out.vsync;
    assign hblnk_out  = timing_out.hblnk;
    assign vblnk_out  = timing_out.vblnk;

endmodule

`default_nettype wire

//--- tests/draw_model.svh
`ifndef DRAW_MODEL_SVH
`define DRAW_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// reference model of the drawing stage
//////////////////////////////////////////////////////////////////////

// stand in for the external font rom
function automatic logic [7:0] font_byte(input logic [7:0] xy, input logic [3:0] line);
    logic [7:0] mixed;
    mixed = {4'b0000, line} * 8'h1d;
    return xy ^ mixed;
endfunction

// galois form, shifts right
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
        n = n ^ 32'h8020_0003;
    return n;
endfunction

// box of the current screen, none on the blank screen
function automatic logic in_caption(input coord_t h, input coord_t v, input logic se,
                                    input logic ce, output coord_t row, output coord_t col);
    coord_t x0;
    coord_t y0;
    coord_t w;
    x0 = 11'd0;
    y0 = 11'd0;
    w  = 11'd0;
    if (!se)
    begin
        x0 = START_CAP_X;
        y0 = START_CAP_Y;
        w  = START_CAP_W;
    end
    else if (ce)
    begin
        x0 = CHOICE_CAP_X;
        y0 = CHOICE_CAP_Y;
        w  = CHOICE_CAP_W;
    end
    row = v - y0;
    col = h - x0;
    return (w != 11'd0) && (v >= y0) && (v < y0 + CAP_H) && (h >= x0) && (h < x0 + w);
endfunction

function automatic rgb_t model_rgb(input coord_t h, input coord_t v, input logic se,
                                   input logic ce);
    coord_t     row;
    coord_t     col;
    logic [7:0] glyph;
    stroke_t    s;
    if (in_caption(h, v, se, ce, row, col))
    begin
        glyph = font_byte({row[7:4], col[6:3]}, row[3:0]);
        return glyph[3'd7 - col[2:0]] ? LETTER_COLOR : CAPTION_BG;  // msb is leftmost
    end
    if (!se)
    begin
        for (int i = 0; i < NUM_STROKES; i++)
        begin
            s = TITLE_STROKES[i];
            if (s.dir == STROKE_H && v == s.pos + TITLE_Y_OFS
                && h >= s.span_lo + TITLE_X_OFS && h <= s.span_hi + TITLE_X_OFS)
                return RED;
            if (s.dir == STROKE_V && h == s.pos + TITLE_X_OFS
                && v >= s.span_lo + TITLE_Y_OFS && v <= s.span_hi + TITLE_Y_OFS)
                return RED;
        end
        if (h >= START_TILE_X0 && h <= START_TILE_X1
            && v >= START_TILE_Y0 && v <= START_TILE_Y1)
            return (v <= START_TILE_YMID) ? YELLOW : BLUE;
    end
    else if (ce && v >= CHOICE_TILE_Y0 && v <= CHOICE_TILE_Y1)
    begin
        if (h >= CHOICE_LEFT_X0 && h <= CHOICE_LEFT_X1)
            return BLUE;
        if (h >= CHOICE_RIGHT_X0 && h <= CHOICE_RIGHT_X1)
            return YELLOW;
    end
    return BACKGROUND;
endfunction

`endif

//--- tests/tb_draw_screen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_draw_screen;

    import draw_pkg::*;

    `include "draw_model.svh"

    localparam int          RESET_CYCLES = 8;
    localparam int          WAIT_LIMIT   = 20;
    localparam logic [31:0] LFSR_SEED    = 32'h8c69_fa09;

    logic        pclk;
    logic        rst;
    coord_t      hcount_in;
    coord_t      vcount_in;
    logic        hsync_in;
    logic        vsync_in;
    logic        hblnk_in;
    logic        vblnk_in;
    logic        start_en;
    logic        choice_en;
    logic [7:0]  char_pixels;
    coord_t      hcount_out;
    coord_t      vcount_out;
    logic        hsync_out;
    logic        vsync_out;
    logic        hblnk_out;
    logic        vblnk_out;
    rgb_t        rgb_out;
    logic [7:0]  char_xy;
    logic [3:0]  char_line;

    logic [31:0] lfsr_state;
    logic        exp_valid;     // output register holds a known pixel
    coord_t      exp_h;
    coord_t      exp_v;
    logic [3:0]  exp_flags;     // hsync vsync hblnk vblnk
    rgb_t        exp_rgb;

    draw_screen_top dut (
        .pclk        (pclk),
        .rst         (rst),
        .hcount_in   (hcount_in),
        .vcount_in   (vcount_in),
        .hsync_in    (hsync_in),
        .vsync_in    (vsync_in),
        .hblnk_in    (hblnk_in),
        .vblnk_in    (vblnk_in),
        .start_en    (start_en),
        .choice_en   (choice_en),
        .char_pixels (char_pixels),
        .hcount_out  (hcount_out),
        .vcount_out  (vcount_out),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .hblnk_out   (hblnk_out),
        .vblnk_out   (vblnk_out),
        .rgb_out     (rgb_out),
        .char_xy     (char_xy),
        .char_line   (char_line)
    );

    assign char_pixels = font_byte(char_xy, char_line);    // combinational font rom

    initial
    begin
        pclk = 1'b0;
        forever #2 pclk = ~pclk;
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic report_failure();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t want);
        if (got !== want)
        begin
            $display("Fail %s: got %h, expected %h", name, got, want);
            report_failure();
        end
    endtask

    task automatic check_coord(input string name, input coord_t got, input coord_t want);
        if (got !== want)
        begin
            $display("Fail %s: got %h, expected %h", name, got, want);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want)
        begin
            $display("Fail %s: got %h, expected %h", name, got, want);
            report_failure();
        end
    endtask

    // char_xy and char_line side by side
    task automatic check_addr(input string name, input logic [11:0] got,
                              input logic [11:0] want);
        if (got !== want)
        begin
            $display("Fail %s: got %h, expected %h", name, got, want);
            report_failure();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    function automatic void stroke_mid(input int i, output coord_t h, output coord_t v);
        stroke_t s;
        s = TITLE_STROKES[i];
        if (s.dir == STROKE_H)
        begin
            h = coord_t'((s.span_lo + s.span_hi) >> 1) + TITLE_X_OFS;
            v = s.pos + TITLE_Y_OFS;
        end
        else
        begin
            h = s.pos + TITLE_X_OFS;
            v = coord_t'((s.span_lo + s.span_hi) >> 1) + TITLE_Y_OFS;
        end
    endfunction

    // registered outputs read zero while reset was seen at the last edge
    task automatic check_outputs();
        coord_t     want_h;
        coord_t     want_v;
        logic [3:0] want_f;
        rgb_t       want_rgb;
        if (rst || exp_valid)
        begin
            want_h   = rst ? 11'd0 : exp_h;
            want_v   = rst ? 11'd0 : exp_v;
            want_f   = rst ? 4'h0 : exp_flags;
            want_rgb = rst ? 12'h000 : exp_rgb;
            check_coord("hcount_out", hcount_out, want_h);
            check_coord("vcount_out", vcount_out, want_v);
            check_bit("hsync_out", hsync_out, want_f[3]);
            check_bit("vsync_out", vsync_out, want_f[2]);
            check_bit("hblnk_out", hblnk_out, want_f[1]);
            check_bit("vblnk_out", vblnk_out, want_f[0]);
            check_rgb("rgb_out", rgb_out, want_rgb);
        end
    endtask

    // one pixel per clock while the previous one is checked at the output
    task automatic step_expect(input coord_t h, input coord_t v, input logic [3:0] flags,
                               input logic se, input logic ce, input rgb_t want);
        coord_t row;
        coord_t col;
        @(posedge pclk);
        #1;
        check_outputs();
        hcount_in = h;
        vcount_in = v;
        {hsync_in, vsync_in, hblnk_in, vblnk_in} = flags;
        start_en  = se;
        choice_en = ce;
        exp_valid = 1'b1;
        exp_h     = h;
        exp_v     = v;
        exp_flags = flags;
        exp_rgb   = want;
        #1;
        if (in_caption(h, v, se, ce, row, col))     // font address leaves in the same cycle
            check_addr("char_xy/char_line", {char_xy, char_line},
                       {row[7:4], col[6:3], row[3:0]});
    endtask

    task automatic step_pixel(input coord_t h, input coord_t v, input logic [3:0] flags,
                              input logic se, input logic ce);
        step_expect(h, v, flags, se, ce, model_rgb(h, v, se, ce));
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_sequence();
        logic [31:0] r;
        int          n;
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            take_bits(26, r);
            step_pixel(r[10:0], r[21:11], r[25:22], 1'b0, 1'b0);
        end
        rst = 1'b0;
        n = 0;
        while (hcount_out !== exp_h || vcount_out !== exp_v)
        begin
            if (n == WAIT_LIMIT)
            begin
                $display("Timeout: outputs never followed the input after reset");
                report_failure();
            end
            @(posedge pclk);
            #1;
            n++;
        end
    endtask

    task automatic pass_through();
        logic [31:0] r;
        for (int i = 0; i < 200; i++)
        begin
            take_bits(28, r);
            step_pixel(r[10:0], r[21:11], r[25:22], r[26], r[27]);
        end
    endtask

    task automatic start_screen();
        coord_t      h;
        coord_t      v;
        logic [31:0] r;
        for (int i = 0; i < NUM_STROKES; i++)
        begin
            stroke_mid(i, h, v);
            step_expect(h, v, 4'h0, 1'b0, 1'b0, RED);
        end
        for (int x = 320; x <= 480; x += 16)
        begin
            step_expect(coord_t'(x), 11'd400, 4'h0, 1'b0, 1'b0, YELLOW);
            step_expect(coord_t'(x), 11'd480, 4'h0, 1'b0, 1'b0, YELLOW);
            step_expect(coord_t'(x), 11'd481, 4'h0, 1'b0, 1'b0, BLUE);
            step_expect(coord_t'(x), 11'd560, 4'h0, 1'b0, 1'b0, BLUE);
        end
        step_expect(11'd319, 11'd450, 4'h0, 1'b0, 1'b0, BACKGROUND);   // just outside
        step_expect(11'd481, 11'd450, 4'h0, 1'b0, 1'b0, BACKGROUND);
        step_expect(11'd400, 11'd561, 4'h0, 1'b0, 1'b0, BACKGROUND);
        for (int i = 0; i < 300; i++)
        begin
            take_bits(24, r);
            step_pixel({1'b0, r[9:0]}, {1'b0, r[19:10]}, r[23:20], 1'b0, 1'b0);
        end
    endtask

    task automatic start_caption();
        for (int y = 600; y < 615; y++)
            for (int x = 490; x < 530; x++)
                step_pixel(coord_t'(x), coord_t'(y), 4'h0, 1'b0, 1'b0);
        step_expect(11'd489, 11'd605, 4'h0, 1'b0, 1'b0, BACKGROUND);
        step_expect(11'd530, 11'd605, 4'h0, 1'b0, 1'b0, BACKGROUND);
        step_expect(11'd500, 11'd615, 4'h0, 1'b0, 1'b0, BACKGROUND);
    endtask

    task automatic choice_screen();
        coord_t h;
        coord_t v;
        for (int y = 300; y < 315; y++)
            for (int x = 470; x < 580; x++)
                step_pixel(coord_t'(x), coord_t'(y), 4'h0, 1'b1, 1'b1);
        step_expect(11'd300, 11'd450, 4'h0, 1'b1, 1'b1, BLUE);
        step_expect(11'd350, 11'd500, 4'h0, 1'b1, 1'b1, BLUE);
        step_expect(11'd400, 11'd550, 4'h0, 1'b1, 1'b1, BLUE);
        step_expect(11'd650, 11'd450, 4'h0, 1'b1, 1'b1, YELLOW);
        step_expect(11'd700, 11'd500, 4'h0, 1'b1, 1'b1, YELLOW);
        step_expect(11'd750, 11'd550, 4'h0, 1'b1, 1'b1, YELLOW);
        step_expect(11'd401, 11'd500, 4'h0, 1'b1, 1'b1, BACKGROUND);
        step_expect(11'd649, 11'd500, 4'h0, 1'b1, 1'b1, BACKGROUND);
        step_expect(11'd350, 11'd449, 4'h0, 1'b1, 1'b1, BACKGROUND);
        // no title on this screen
        stroke_mid(0, h, v);
        step_expect(h, v, 4'h0, 1'b1, 1'b1, BACKGROUND);
        stroke_mid(1, h, v);
        step_expect(h, v, 4'h0, 1'b1, 1'b1, BACKGROUND);
    endtask

    task automatic blank_screen();
        coord_t      h;
        coord_t      v;
        logic [31:0] r;
        for (int i = 0; i < NUM_STROKES; i++)
        begin
            stroke_mid(i, h, v);
            step_expect(h, v, 4'h0, 1'b1, 1'b0, BACKGROUND);
        end
        step_expect(11'd400, 11'd420, 4'h0, 1'b1, 1'b0, BACKGROUND);  // start tiles
        step_expect(11'd400, 11'd520, 4'h0, 1'b1, 1'b0, BACKGROUND);
        step_expect(11'd350, 11'd500, 4'h0, 1'b1, 1'b0, BACKGROUND);  // choice tiles
        step_expect(11'd700, 11'd500, 4'h0, 1'b1, 1'b0, BACKGROUND);
        step_expect(11'd500, 11'd605, 4'h0, 1'b1, 1'b0, BACKGROUND);  // caption spots
        step_expect(11'd500, 11'd305, 4'h0, 1'b1, 1'b0, BACKGROUND);
        for (int i = 0; i < 200; i++)
        begin
            take_bits(24, r);
            step_expect({1'b0, r[9:0]}, {1'b0, r[19:10]}, r[23:20], 1'b1, 1'b0, BACKGROUND);
        end
    endtask

    initial
    begin
        rst        = 1'b1;
        hcount_in  = 11'd0;
        vcount_in  = 11'd0;
        hsync_in   = 1'b0;
        vsync_in   = 1'b0;
        hblnk_in   = 1'b0;
        vblnk_in   = 1'b0;
        start_en   = 1'b0;
        choice_en  = 1'b0;
        lfsr_state = LFSR_SEED;
        exp_valid  = 1'b0;
        exp_h      = 11'd0;
        exp_v      = 11'd0;
        exp_flags  = 4'h0;
        exp_rgb    = 12'h000;
        reset_sequence();
        pass_through();
        start_screen();
        start_caption();
        choice_screen();
        blank_screen();
        @(posedge pclk);
        #1;
        check_outputs();    // last pixel still in the output register
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+tests
hw/draw_pkg.sv
hw/vga_timing_if.sv
hw/title_renderer.sv
hw/caption_locator.sv
hw/tile_renderer.sv
hw/pixel_mixer.sv
hw/draw_screen_top.sv
tests/tb_draw_screen.sv
